// ==== build.f ====
design/dp_lb_pkg.sv
design/dp_irq_pkg.sv
design/dp_lib_edge.sv
design/dp_pm_irq.sv
design/dp_pm_timer.sv
design/dp_pm_lb_dec.sv
design/dp_pm_top.sv
test/dp_pm_tb.sv

// ==== test/dp_pm_tb.sv ====
/*
	Testbench for the DP policy-manager peripheral cluster
	Directed tests of the register map, interrupts and timer over the local bus
*/

`timescale 1ns/1ps

module dp_pm_tb
	import dp_lb_pkg::*;
	import dp_irq_pkg::*;
();

	// Full local-bus addresses
	localparam logic [3:0] A_SET  = {LB_REGION_IRQ, IRQ_ADR_SET};
	localparam logic [3:0] A_CLR  = {LB_REGION_IRQ, IRQ_ADR_CLR};
	localparam logic [3:0] A_STA  = {LB_REGION_IRQ, IRQ_ADR_STA};
	localparam logic [3:0] A_TCTL = {LB_REGION_TMR, TMR_ADR_CTL};
	localparam logic [3:0] A_TRLD = {LB_REGION_TMR, TMR_ADR_RLD};
	localparam logic [3:0] A_TCNT = {LB_REGION_TMR, TMR_ADR_CNT};

	// Cycle budget per test, timer test covers the longest period
	localparam int BUDGET = 60 + 60 + 150 + 80 + 80 + 400;
	localparam int WD_NS  = BUDGET * 10 + 1000;		// Plus margin

	logic       clk;		// To RST_IN
	logic       rst;		// To CLK_IN
	lb_req_t    lb_req;
	lb_rsp_t    lb_rsp;
	logic [6:0] irq_src;
	logic       irq;

	logic [31:0] lfsr_state = 32'h66d38f09;
	int          cyc;			// Cycle counter
	int          errors;
	int          test_err;		// Errors in the running test
	int          tests_run;
	int          tests_failed;
	string       cur_test;

	dp_pm_top dp_pm_top_i
	(
		.RST_IN  (clk),
		.CLK_IN  (rst),
		.lb_req  (lb_req),
		.lb_rsp  (lb_rsp),
		.irq_src (irq_src),
		.irq     (irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// Status word: events in bits 8..1, any-pending in bit 0
	function automatic logic [31:0] status_of(input logic [7:0] evt);
		return {23'd0, evt, |evt};
	endfunction

	// Control word: modes, enables, run
	function automatic logic [31:0] ctl_word(input logic run, input logic [7:0] ie,
		input logic [7:0] mode);
		return {15'd0, mode, ie, run};
	endfunction

	task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("ERR %s %s: expected %h, actual %h", cur_test, label, exp, act);
			errors++;
			test_err++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_err != 0)
			tests_failed++;
		$display("%s: %s (%0d errors)", cur_test, (test_err == 0) ? "ok" : "failed", test_err);
	endtask

	// Write strobe for one cycle, lands one edge after sampling
	task automatic lb_write(input logic [3:0] adr, input logic [31:0] data);
		@(posedge clk);
		lb_req <= '{adr: adr, wr: 1'b1, rd: 1'b0, din: data};
		@(posedge clk);
		lb_req.wr <= 1'b0;
	endtask

	// Read strobe, answer sampled mid-cycle after the sampling edge
	task automatic lb_read(input logic [3:0] adr, output logic [31:0] data);
		@(posedge clk);
		lb_req <= '{adr: adr, wr: 1'b0, rd: 1'b1, din: 32'd0};
		@(posedge clk);
		lb_req.rd <= 1'b0;
		@(negedge clk);
		data = lb_rsp.dout;
		if (lb_rsp.vld !== 1'b1)
		begin
			$display("%s: read of address %h was not answered with vld", cur_test, adr);
			errors++;
			test_err++;
		end
	endtask

	task automatic reset_map();
		logic [31:0] d;
		logic [3:0]  unmapped[4] = '{4'h3, 4'h7, 4'h8, 4'hc};
		begin_test("reset_map");
		lb_read(A_SET, d);
		check("ctl set", 32'd0, d);
		lb_read(A_CLR, d);
		check("ctl clr", 32'd0, d);
		lb_read(A_STA, d);
		check("status", 32'd0, d);
		lb_read(A_TCTL, d);
		check("timer ctl", 32'd0, d);
		lb_read(A_TCNT, d);
		check("timer count", 32'd0, d);
		check("irq", 32'd0, irq);
		foreach (unmapped[i])
		begin
			lb_read(unmapped[i], d);
			check("unmapped", LB_UNMAPPED, d);
		end
		end_test();
	endtask

	task automatic ctl_set_clr();
		logic [31:0] d;
		logic [31:0] mask;
		logic [31:0] model;
		begin_test("ctl_set_clr");
		model = '0;
		repeat (4)
		begin
			mask  = lfsr_bits(32);
			model = (model | mask) & 32'h1ffff;		// 17-bit word
			lb_write(A_SET, mask);
			lb_read(A_SET, d);
			check("after set", model, d);
			mask  = lfsr_bits(32);
			model = model & ~mask & 32'h1ffff;
			lb_write(A_CLR, mask);
			lb_read(A_CLR, d);
			check("after clr", model, d);
		end
		lb_write(A_CLR, 32'h1ffff);
		end_test();
	endtask

	task automatic level_irq();
		logic [31:0] d;
		logic [7:0]  ie;
		logic [6:0]  src;
		logic [7:0]  exp;
		begin_test("level_irq");
		ie = 8'(lfsr_bits(8));
		lb_write(A_SET, ctl_word(1'b1, ie, 8'h00));
		repeat (4)
		begin
			src = 7'(lfsr_bits(7));
			exp = ie & {src, 1'b0};				// Source 0 idle, timer off
			@(posedge clk);
			irq_src <= src;
			lb_read(A_STA, d);
			check("status", status_of(exp), d);
			check("irq", exp != 0, irq);
			lb_write(A_STA, 32'h1fe);			// Sources still high
			lb_read(A_STA, d);
			check("held status", status_of(exp), d);
			@(posedge clk);
			irq_src <= '0;
			lb_write(A_STA, 32'h1fe);
			lb_read(A_STA, d);
			check("cleared status", 32'd0, d);
			check("irq low", 32'd0, irq);
		end
		lb_write(A_CLR, 32'h1ffff);
		end_test();
	endtask

	task automatic edge_irq();
		logic [31:0] d;
		logic [7:0]  ie;
		begin_test("edge_irq");
		ie = 8'(lfsr_bits(8)) & 8'hfe;
		lb_write(A_SET, ctl_word(1'b1, ie, 8'hfe));
		@(posedge clk);
		irq_src <= 7'h7f;		// One-cycle pulse on every source
		@(posedge clk);
		irq_src <= '0;
		lb_read(A_STA, d);
		check("pulse latched", status_of(ie), d);
		check("irq", ie != 0, irq);
		lb_write(A_STA, 32'h1fe);
		@(posedge clk);
		irq_src <= 7'h7f;		// Rise and hold
		lb_write(A_STA, 32'h1fe);
		lb_read(A_STA, d);
		check("held high", 32'd0, d);
		@(posedge clk);
		irq_src <= '0;
		lb_read(A_STA, d);
		check("after fall", 32'd0, d);
		lb_write(A_CLR, 32'h1ffff);
		end_test();
	endtask

	task automatic run_gate();
		logic [31:0] d;
		logic [6:0]  src;
		begin_test("run_gate");
		src = 7'(lfsr_bits(7)) | 7'h01;
		lb_write(A_SET, ctl_word(1'b1, 8'hfe, 8'h00));
		@(posedge clk);
		irq_src <= src;
		@(posedge clk);
		irq_src <= '0;
		lb_read(A_STA, d);
		check("pending", status_of({src, 1'b0}), d);
		lb_write(A_CLR, 32'h1);			// Stop
		lb_read(A_STA, d);
		check("stopped", 32'd0, d);
		check("irq stopped", 32'd0, irq);
		lb_write(A_SET, 32'h1);			// Restart, sources low
		lb_read(A_STA, d);
		check("restarted", 32'd0, d);
		check("irq restarted", 32'd0, irq);
		@(posedge clk);
		irq_src <= src;
		lb_read(A_STA, d);
		check("asserted again", status_of({src, 1'b0}), d);
		@(posedge clk);
		irq_src <= '0;
		lb_write(A_CLR, 32'h1ffff);
		end_test();
	endtask

	task automatic timer_irq();
		logic [31:0] d;
		logic [31:0] r;
		int          t_end;
		int          n_exp;
		begin_test("timer_irq");
		r = lfsr_bits(5) + 8;			// 8..39, leaves room to clear each event
		lb_write(A_TRLD, r);
		lb_read(A_TRLD, d);
		check("reload", r, d);
		lb_write(A_SET, ctl_word(1'b1, 8'h01, 8'h01));	// Source 0 edge mode
		lb_write(A_TCTL, 32'h1);
		t_end = cyc + 4 * (r + 1) + 5;	// Four periods plus start latency
		n_exp = 0;
		while (cyc < t_end)
		begin
			@(negedge clk);
			if (irq)
			begin
				n_exp++;
				lb_read(A_STA, d);
				check("expiry status", status_of(8'h01), d);
				lb_write(A_STA, 32'h2);
				@(posedge clk);			// Let the clear land
			end
		end
		check("expiry count", 32'd4, n_exp);
		lb_write(A_TCTL, 32'h0);
		lb_write(A_STA, 32'h1fe);
		repeat (2 * (r + 1)) @(posedge clk);
		lb_read(A_STA, d);
		check("stopped status", 32'd0, d);
		check("irq stopped", 32'd0, irq);
		end_test();
	endtask

	// Watchdog
	initial
	begin
		#(WD_NS);
		$display("Timeout: tests did not finish within %0d ns", WD_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		rst          = 1'b1;
		lb_req       = '0;
		irq_src      = '0;
		cyc          = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		reset_map();
		ctl_set_clr();
		level_irq();
		edge_irq();
		run_gate();
		timer_irq();
		$display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== design/dp_pm_top.sv ====
/*
	DP policy-manager peripheral cluster
	Decoder, interrupt controller and interval timer on one local bus
*/

`timescale 1ns/1ps

module dp_pm_top
	import dp_lb_pkg::*;
(
	input  logic       RST_IN,		// Clock
	input  logic       CLK_IN,		// Async reset, active high
	input  lb_req_t    lb_req,		// Local-bus request
	output lb_rsp_t    lb_rsp,		// Local-bus response
	input  logic [6:0] irq_src,		// Interrupt sources 1 to 7
	output logic       irq			// Interrupt to the CPU
);

	blk_req_t irq_req;			// Decoder to interrupt controller
	blk_req_t tmr_req;			// Decoder to timer
	lb_rsp_t  irq_rsp;
	lb_rsp_t  tmr_rsp;
	logic     tmr_expire;		// Timer drives source 0

	dp_pm_lb_dec lb_dec_i
	(
		.RST_IN  (RST_IN),
		.CLK_IN  (CLK_IN),
		.lb_req  (lb_req),
		.irq_req (irq_req),
		.tmr_req (tmr_req),
		.irq_rsp (irq_rsp),
		.tmr_rsp (tmr_rsp),
		.lb_rsp  (lb_rsp)
	);

	dp_pm_irq irq_i
	(
		.RST_IN  (RST_IN),
		.CLK_IN  (CLK_IN),
		.blk_req (irq_req),
		.blk_rsp (irq_rsp),
		.irq_req ({irq_src, tmr_expire}),	// Timer in bit 0
		.irq     (irq)
	);

	dp_pm_timer timer_i
	(
		.RST_IN  (RST_IN),
		.CLK_IN  (CLK_IN),
		.blk_req (tmr_req),
		.blk_rsp (tmr_rsp),
		.expire  (tmr_expire)
	);

endmodule

// ==== design/dp_pm_lb_dec.sv ====
/*
	Local-bus region decoder
	Steers strobes to one block by adr[3:2] and muxes the read answer
*/

`timescale 1ns/1ps

module dp_pm_lb_dec
	import dp_lb_pkg::*;
(
	input  logic     RST_IN,		// Clock
	input  logic     CLK_IN,		// Async reset, active high
	input  lb_req_t  lb_req,		// Shared port request
	output blk_req_t irq_req,		// To interrupt controller
	output blk_req_t tmr_req,		// To timer
	input  lb_rsp_t  irq_rsp,
	input  lb_rsp_t  tmr_rsp,
	output lb_rsp_t  lb_rsp			// Shared port response
);

	logic [LB_ADR_W-BLK_ADR_W-1:0] region;		// Selected region
	logic [LB_ADR_W-BLK_ADR_W-1:0] region_r;	// Region of the last request
	logic                          rd_pend;		// Read issued last cycle

	assign region = lb_req.adr[LB_ADR_W-1:BLK_ADR_W];

	// Address and data go to both, strobes only to one
	always_comb
	begin
		irq_req.adr = lb_req.adr[BLK_ADR_W-1:0];
		irq_req.din = lb_req.din;
		irq_req.wr  = lb_req.wr && (region == LB_REGION_IRQ);
		irq_req.rd  = lb_req.rd && (region == LB_REGION_IRQ);
		tmr_req.adr = lb_req.adr[BLK_ADR_W-1:0];
		tmr_req.din = lb_req.din;
		tmr_req.wr  = lb_req.wr && (region == LB_REGION_TMR);
		tmr_req.rd  = lb_req.rd && (region == LB_REGION_TMR);
	end

	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			region_r <= '0;
			rd_pend  <= 1'b0;
		end
		else
		begin
			region_r <= region;
			rd_pend  <= lb_req.rd;
		end
	end

	// Response mux, unmapped regions answered here
	always_comb
	begin
		case (region_r)
			LB_REGION_IRQ : lb_rsp = irq_rsp;
			LB_REGION_TMR : lb_rsp = tmr_rsp;
			default       : lb_rsp = '{dout: LB_UNMAPPED, vld: rd_pend};
		endcase
	end

	// At most one block answers in a cycle
	a_one_vld : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		!(irq_rsp.vld && tmr_rsp.vld));

	// Every read is answered on the next cycle, and only then
	a_rd_vld : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		lb_rsp.vld == $past(lb_req.rd));

endmodule

// ==== design/dp_pm_timer.sv ====
/*
	Interval timer
	Down counter with run control and reload, pulses expire on wrap
*/

`timescale 1ns/1ps

module dp_pm_timer
	import dp_lb_pkg::*;
(
	input  logic     RST_IN,		// Clock
	input  logic     CLK_IN,		// Async reset, active high
	input  blk_req_t blk_req,		// Register request
	output lb_rsp_t  blk_rsp,		// Read response
	output logic     expire			// One cycle per period
);

	// Registered request
	logic                 wr_r;
	logic                 rd_r;
	logic [BLK_ADR_W-1:0] adr_r;
	logic [LB_DAT_W-1:0]  din_r;

	logic                run;		// Counting enabled
	logic [LB_DAT_W-1:0] reload;	// Period minus one
	logic [LB_DAT_W-1:0] cnt;		// Current count
	logic                start;		// Run going 0 to 1

	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			wr_r <= 1'b0;
			rd_r <= 1'b0;
		end
		else
		begin
			wr_r <= blk_req.wr;
			rd_r <= blk_req.rd;
		end
	end

	always_ff @(posedge RST_IN)
	begin
		adr_r <= blk_req.adr;
		din_r <= blk_req.din;
	end

	assign start = wr_r && (adr_r == TMR_ADR_CTL) && din_r[0] && !run;

	// Control and reload registers
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			run    <= 1'b0;
			reload <= '0;
		end
		else if (wr_r)
		begin
			case (adr_r)
				TMR_ADR_CTL : run    <= din_r[0];
				TMR_ADR_RLD : reload <= din_r;
				default     : ;				// Count is read only
			endcase
		end
	end

	// Counter and expiry pulse
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			cnt    <= '0;
			expire <= 1'b0;
		end
		else
		begin
			expire <= 1'b0;
			if (start)
				cnt <= reload;				// Fresh period on start
			else if (run)
			begin
				if (cnt == '0)
				begin
					cnt    <= reload;		// Wrap
					expire <= 1'b1;
				end
				else
					cnt <= cnt - 1'b1;
			end
		end
	end

	always_comb
	begin
		blk_rsp.vld = rd_r;
		case (adr_r)
			TMR_ADR_CTL : blk_rsp.dout = LB_DAT_W'(run);
			TMR_ADR_RLD : blk_rsp.dout = reload;
			TMR_ADR_CNT : blk_rsp.dout = cnt;
			default     : blk_rsp.dout = LB_UNMAPPED;
		endcase
	end

	// Nonzero period means single-cycle pulses
	a_exp_pulse : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		(expire && (reload != '0)) |=> !expire);

endmodule

// ==== design/dp_pm_irq.sv ====
/*
	Interrupt controller, eight sources
	Set/clear control word, per-source level or edge event latches,
	write-one-to-clear status and a combined interrupt output
*/

`timescale 1ns/1ps

module dp_pm_irq
	import dp_lb_pkg::*;
	import dp_irq_pkg::*;
(
	input  logic               RST_IN,		// Clock
	input  logic               CLK_IN,		// Async reset, active high
	input  blk_req_t           blk_req,		// Register request
	output lb_rsp_t            blk_rsp,		// Read response
	input  logic [IRQ_NUM-1:0] irq_req,		// Interrupt requests
	output logic               irq			// Any event pending
);

	// Registered request
	logic                 wr_r;
	logic                 rd_r;
	logic [BLK_ADR_W-1:0] adr_r;
	logic [LB_DAT_W-1:0]  din_r;

	// Address decode
	logic sel_set;
	logic sel_clr;
	logic sel_sta;

	// Control word, current and next
	irq_ctl_u ctl;
	irq_ctl_u ctl_nxt;

	// Events
	logic [IRQ_NUM-1:0]       req_re;		// Request rising edges
	logic [IRQ_NUM-1:0]       evt_set;
	logic [IRQ_NUM-1:0]       evt_clr;
	logic [IRQ_NUM-1:0]       evt;
	logic [IRQ_STA_WIDTH-1:0] sta;

	// Registered strobes
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			wr_r <= 1'b0;
			rd_r <= 1'b0;
		end
		else
		begin
			wr_r <= blk_req.wr;
			rd_r <= blk_req.rd;
		end
	end

	// Registered address and data
	always_ff @(posedge RST_IN)
	begin
		adr_r <= blk_req.adr;
		din_r <= blk_req.din;
	end

	assign sel_set = (adr_r == IRQ_ADR_SET);
	assign sel_clr = (adr_r == IRQ_ADR_CLR);
	assign sel_sta = (adr_r == IRQ_ADR_STA);

	// Next control word
	always_comb
	begin
		ctl_nxt = ctl;
		if (wr_r && sel_set)
			ctl_nxt.raw = ctl.raw | din_r[IRQ_CTL_WIDTH-1:0];		// OR bits in
		else if (wr_r && sel_clr)
			ctl_nxt.raw = ctl.raw & ~din_r[IRQ_CTL_WIDTH-1:0];	// Clear bits
	end

	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			ctl.raw <= '0;
		else
			ctl.raw <= ctl_nxt.raw;
	end

	// One edge detector per source
	for (genvar i = 0; i < IRQ_NUM; i++)
	begin : g_edge
		dp_lib_edge edge_i
		(
			.RST_IN (RST_IN),
			.CLK_IN (CLK_IN),
			.a_in   (irq_req[i]),
			.re     (req_re[i]),
			.fe     ()				// Falling edge not needed
		);
	end

	// Set from level or edge, per mode
	always_comb
	begin
		for (int i = 0; i < IRQ_NUM; i++)
			evt_set[i] = ctl_nxt.f.ie[i] &&
				(ctl_nxt.f.mode[i] ? req_re[i] : irq_req[i]);
	end

	// Ones written to status clear events
	assign evt_clr = {IRQ_NUM{wr_r && sel_sta}} & din_r[IRQ_STA_EVT +: IRQ_NUM];

	// Event latches
	// Follow the next run bit so events drop with run in the same cycle
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			evt <= '0;
		else if (!ctl_nxt.f.run)
			evt <= '0;							// Stopped, flush all
		else
			evt <= (evt | evt_set) & ~evt_clr;	// Clear wins over set
	end

	// Status word
	assign sta[IRQ_STA_ALL]             = |evt;
	assign sta[IRQ_STA_EVT +: IRQ_NUM] = evt;

	assign irq = sta[IRQ_STA_ALL];

	// Read mux from the registered request
	always_comb
	begin
		blk_rsp.vld  = rd_r;		// Fixed one-cycle latency
		blk_rsp.dout = LB_UNMAPPED;
		if (sel_set || sel_clr)
			blk_rsp.dout = LB_DAT_W'(ctl.raw);	// Both addresses read control
		else if (sel_sta)
			blk_rsp.dout = LB_DAT_W'(sta);
	end

	// Interrupt stays low while stopped
	a_irq_run : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		!ctl.f.run |-> !irq);

endmodule

// ==== design/dp_lib_edge.sv ====
/*
	Edge detector
	Flags rising and falling edges of one line against its registered copy
*/

`timescale 1ns/1ps

module dp_lib_edge
(
	input  logic RST_IN,	// Clock
	input  logic CLK_IN,	// Async reset, active high
	input  logic a_in,		// Line to watch
	output logic re,		// Rising edge
	output logic fe			// Falling edge
);

	logic a_r;		// Previous value

	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			a_r <= 1'b0;
		else
			a_r <= a_in;
	end

	// Combinational against the stored copy
	assign re = a_in & ~a_r;
	assign fe = ~a_in & a_r;

endmodule

// ==== design/dp_irq_pkg.sv ====
/*
	Interrupt controller register layout
	Control and status bit positions and the control word union
*/

package dp_irq_pkg;

	// Source count
	localparam int IRQ_NUM = 8;

	// Control word
	// Bit 0 run, bits 1..8 enables, bits 9..16 modes
	localparam int IRQ_CTL_WIDTH = 1 + 2 * IRQ_NUM;	// 17 bits

	// Status word
	// Bit 0 any pending, bits 1..8 per-source events
	localparam int IRQ_STA_WIDTH = 1 + IRQ_NUM;		// 9 bits
	localparam int IRQ_STA_ALL   = 0;				// Any-pending flag
	localparam int IRQ_STA_EVT   = 1;				// First event bit

	// Register addresses inside the block
	localparam logic [1:0] IRQ_ADR_SET = 2'd0;	// Write ORs bits into control
	localparam logic [1:0] IRQ_ADR_CLR = 2'd1;	// Write clears control bits
	localparam logic [1:0] IRQ_ADR_STA = 2'd2;	// Status, write one to clear

	// Field view of the control word
	// First member lands in the top bits
	typedef struct packed {
		logic [IRQ_NUM-1:0] mode;	// 0 level, 1 edge
		logic [IRQ_NUM-1:0] ie;		// Per-source enable
		logic               run;	// Global run
	} irq_ctl_fields_t;

	// Control word, written raw and read as fields
	typedef union packed {
		logic [IRQ_CTL_WIDTH-1:0] raw;
		irq_ctl_fields_t          f;
	} irq_ctl_u;

endpackage

// ==== design/dp_lb_pkg.sv ====
/*
	Local bus package for the DP policy-manager peripherals
	Request and response structs plus the address map
*/

package dp_lb_pkg;

	// Bus widths
	localparam int LB_ADR_W  = 4;		// Full local-bus address
	localparam int LB_DAT_W  = 32;		// Data word
	localparam int BLK_ADR_W = 2;		// Register address inside one block

	// Region codes in adr[3:2]
	localparam logic [1:0] LB_REGION_IRQ = 2'd0;	// Interrupt controller
	localparam logic [1:0] LB_REGION_TMR = 2'd1;	// Interval timer

	// Timer register map
	localparam logic [BLK_ADR_W-1:0] TMR_ADR_CTL = 2'd0;	// Bit 0 is run
	localparam logic [BLK_ADR_W-1:0] TMR_ADR_RLD = 2'd1;	// Reload value
	localparam logic [BLK_ADR_W-1:0] TMR_ADR_CNT = 2'd2;	// Current count, read only

	// Returned for any address without a register
	localparam logic [LB_DAT_W-1:0] LB_UNMAPPED = 32'hdeadcafe;

	// Request as seen on the shared port
	typedef struct packed {
		logic [LB_ADR_W-1:0]  adr;
		logic                 wr;		// One-cycle write strobe
		logic                 rd;		// One-cycle read strobe
		logic [LB_DAT_W-1:0]  din;
	} lb_req_t;

	// Read answer, one cycle after rd
	typedef struct packed {
		logic [LB_DAT_W-1:0]  dout;
		logic                 vld;
	} lb_rsp_t;

	// Request after region decode
	typedef struct packed {
		logic [BLK_ADR_W-1:0] adr;
		logic                 wr;
		logic                 rd;
		logic [LB_DAT_W-1:0]  din;
	} blk_req_t;

endpackage
